// ==== cpu.f ====
+incdir+rtl
+incdir+test
rtl/cpu_pkg.sv
rtl/pc_unit.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu.sv
test/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

if ! verilator --binary --timing --assert -f cpu.f --top-module tb_cpu \
	-Mdir "$build_dir" -o tb_cpu; then
	echo "verilator build failed"
	exit 1
fi

if ! "./$build_dir/tb_cpu" > "$log" 2>&1; then
	cat "$log"
	echo "simulation ended with an error status"
	exit 1
fi

cat "$log"

if grep -q "Errors found" "$log"; then
	echo "testbench reported failures"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== test/cpu_ref_model.svh ====
// instruction-level reference model of the core
// builds the random program and records the expected fetch and store streams

`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam logic [7:0] opc_loadi = 8'd0;
localparam logic [7:0] opc_mov   = 8'd1;
localparam logic [7:0] opc_add   = 8'd2;
localparam logic [7:0] opc_sub   = 8'd3;
localparam logic [7:0] opc_and   = 8'd4;
localparam logic [7:0] opc_or    = 8'd5;
localparam logic [7:0] opc_j     = 8'd6;
localparam logic [7:0] opc_beq   = 8'd7;
localparam logic [7:0] opc_lwd   = 8'd8;
localparam logic [7:0] opc_lwi   = 8'd9;
localparam logic [7:0] opc_swd   = 8'd10;
localparam logic [7:0] opc_swi   = 8'd11;

logic [31:0] prog [0:prog_len-1];   // instruction memory image
logic [7:0]  model_regs [0:7];
logic [7:0]  model_mem [0:255];
logic [31:0] exp_fetch [$];         // byte addresses in fetch order
logic [15:0] exp_store [$];         // {address, data} in store order

// ##########################################################################
// program generator
// ##########################################################################
task automatic build_program();
	logic [7:0] op;
	logic [7:0] byte1;   // rd, or the branch offset
	logic [7:0] low;     // imm, or rs2
	logic [2:0] rs1;
	logic [2:0] rs2;
	int         span;
	for (int i = 0; i < rand_count; i++) begin
		op    = 8'($urandom % 12);
		rs1   = 3'($urandom);
		rs2   = ($urandom % 4 == 0) ? rs1 : 3'($urandom);   // equal pairs so beq takes
		byte1 = {5'b0, 3'($urandom)};
		low   = {5'b0, rs2};
		if (op == opc_loadi || op == opc_lwi || op == opc_swi)
			low = 8'($urandom);
		if (op == opc_j || op == opc_beq) begin
			span  = rand_count - i;                             // forward, never past the stores
			byte1 = 8'($urandom % (span < 4 ? span : 4));
		end
		prog[i] = {op, byte1, 5'b0, rs1, low};
	end
	for (int r = 0; r < 8; r++)   // dump every register
		prog[rand_count + r] = {opc_swd, 8'h00, 5'b0, 3'(r), 5'b0, 3'((r + 1) % 8)};
	prog[prog_len - 1] = {opc_j, 8'hff, 16'h0000};   // self-loop
endtask

// ##########################################################################
// execution
// ##########################################################################
task automatic run_model();
	int          pc;        // word index
	int          next_pc;
	int          steps;
	logic [31:0] w;
	logic [7:0]  a;
	logic [7:0]  b;
	logic [7:0]  imm;
	logic [2:0]  rd;
	for (int r = 0; r < 8; r++)
		model_regs[r] = 8'h00;     // cleared by reset
	for (int k = 0; k < 256; k++)
		model_mem[k] = dmem[k];
	pc    = 0;
	steps = 0;
	while (steps < 4 * prog_len) begin
		w = prog[pc];
		exp_fetch.push_back(32'(pc * 4));
		if (pc == prog_len - 1)
			break;                   // self-loop reached
		rd      = w[18:16];
		imm     = w[7:0];
		a       = model_regs[w[10:8]];
		b       = model_regs[w[2:0]];
		next_pc = pc + 1;
		case (w[31:24])
			opc_loadi: model_regs[rd] = imm;
			opc_mov:   model_regs[rd] = b;
			opc_add:   model_regs[rd] = a + b;   // wraps mod 256
			opc_sub:   model_regs[rd] = a - b;
			opc_and:   model_regs[rd] = a & b;
			opc_or:    model_regs[rd] = a | b;
			opc_j:     next_pc = pc + 1 + int'($signed(w[23:16]));
			opc_beq: begin
				if (a == b)
					next_pc = pc + 1 + int'($signed(w[23:16]));
			end
			opc_lwd:   model_regs[rd] = model_mem[b];
			opc_lwi:   model_regs[rd] = model_mem[imm];
			opc_swd: begin
				model_mem[b] = a;
				exp_store.push_back({b, a});
			end
			opc_swi: begin
				model_mem[imm] = a;
				exp_store.push_back({imm, a});
			end
			default: ;
		endcase
		pc    = next_pc;
		steps = steps + 1;
	end
endtask

`endif

// ==== test/tb_cpu.sv ====
// testbench for the 8-bit single-cycle core
// random program, memory models with random waits, fetch and store streams checked

`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

	localparam int clk_period      = 20;
	localparam int rand_count      = 64;                   // random instructions
	localparam int prog_len        = rand_count + 9;       // plus eight stores, self-loop
	localparam int watchdog_cycles = rand_count * 8 + 200;

	logic                    CLK;
	logic                    RESET;
	cpu_pkg::imem_req_t      imem_req;
	logic [`CPU_INSTR_W-1:0] instruction;
	logic                    instr_busywait;
	cpu_pkg::dmem_req_t      dmem_req;
	logic [`CPU_DATA_W-1:0]  readdata;
	logic                    busywait;

	logic [`CPU_DATA_W-1:0]  dmem [0:255];      // data memory contents
	int                      errors      = 0;
	int                      fetch_count = 0;
	int                      fetch_total = 0;
	int                      store_count = 0;
	int                      imem_wait   = 0;   // cycles before the word arrives
	int                      dmem_wait   = 0;   // cycles left on the data access
	logic                    new_fetch   = 1'b1;
	logic                    delivered   = 1'b0; // word valid for the current pc
	logic                    prev_ibusy  = 1'b0;
	logic                    prev_dbusy  = 1'b0;
	cpu_pkg::imem_req_t      prev_imem;
	cpu_pkg::dmem_req_t      prev_dmem;

	`include "cpu_ref_model.svh"

	cpu u_cpu (
		.CLK(CLK),
		.RESET(RESET),
		.imem_req(imem_req),
		.instruction(instruction),
		.instr_busywait(instr_busywait),
		.dmem_req(dmem_req),
		.readdata(readdata),
		.busywait(busywait)
	);

	assign readdata = dmem[dmem_req.address];   // asynchronous read port

	initial begin
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	// ##########################################################################
	// helpers
	// ##########################################################################
	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("FAIL %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		idx = int'(addr[31:2]);
		if (idx < prog_len)
			return prog[idx];
		return 32'h0;
	endfunction

	function automatic logic is_mem_op(input logic [31:0] w);
		return (w[31:24] >= opc_lwd) && (w[31:24] <= opc_swi);   // loads and stores
	endfunction

	// ##########################################################################
	// memory models, sampled at the falling edge
	// ##########################################################################
	task automatic sample_ports();
		logic exp_read;
		logic exp_write;
		if (!RESET) begin
			if (imem_req.read !== 1'b0)
				report_mismatch("reset imem read", 64'd0, 64'(imem_req.read));
			if (dmem_req.read !== 1'b0)
				report_mismatch("reset dmem read", 64'd0, 64'(dmem_req.read));
			if (dmem_req.write !== 1'b0)
				report_mismatch("reset dmem write", 64'd0, 64'(dmem_req.write));
		end
		// data request follows the opcode of a delivered word, idle otherwise
		exp_read  = delivered &&
			(instruction[31:24] == opc_lwd || instruction[31:24] == opc_lwi);
		exp_write = delivered &&
			(instruction[31:24] == opc_swd || instruction[31:24] == opc_swi);
		if (RESET && dmem_req.read !== exp_read)
			report_mismatch("dmem read request", 64'(exp_read), 64'(dmem_req.read));
		if (RESET && dmem_req.write !== exp_write)
			report_mismatch("dmem write request", 64'(exp_write), 64'(dmem_req.write));
		if (prev_ibusy && imem_req !== prev_imem)
			report_mismatch("imem request hold", 64'(prev_imem), 64'(imem_req));
		if (prev_dbusy && dmem_req !== prev_dmem)
			report_mismatch("dmem request hold", 64'(prev_dmem), 64'(dmem_req));
		prev_ibusy = imem_req.read && instr_busywait;
		prev_dbusy = (dmem_req.read || dmem_req.write) && busywait;
		prev_imem  = imem_req;
		prev_dmem  = dmem_req;
		if (dmem_req.write && !busywait) begin   // store taken at this edge
			store_count++;
			if (exp_store.size() == 0) begin
				report_error("store accepted while the model expects none");
			end else begin
				if ({dmem_req.address, dmem_req.writedata} !== exp_store[0])
					report_mismatch("store address/data", 64'(exp_store[0]),
						64'({dmem_req.address, dmem_req.writedata}));
				void'(exp_store.pop_front());
			end
			dmem[dmem_req.address] = dmem_req.writedata;
		end
		if (imem_req.read && !instr_busywait && !busywait) begin   // instruction retires
			if (fetch_count == 0 && imem_req.addr !== 32'd0)
				report_mismatch("first fetch address", 64'd0, 64'(imem_req.addr));
			if (exp_fetch.size() > 0) begin
				if (imem_req.addr !== exp_fetch[0])
					report_mismatch("fetch address", 64'(exp_fetch[0]), 64'(imem_req.addr));
				void'(exp_fetch.pop_front());
				fetch_count++;
			end
			delivered = 1'b0;
			new_fetch = 1'b1;
		end
	endtask

	task automatic drive_memories();
		if (imem_req.read && !delivered) begin
			if (new_fetch) begin
				imem_wait = int'($urandom % 4);   // 0 to 3 wait cycles
				new_fetch = 1'b0;
			end
			if (imem_wait > 0) begin
				imem_wait--;
				instr_busywait = 1'b1;
			end else begin
				instr_busywait = 1'b0;
				instruction    = fetch_word(imem_req.addr);
				delivered      = 1'b1;
				dmem_wait      = is_mem_op(instruction) ? int'($urandom % 4) : 0;
			end
		end
		if (delivered && dmem_wait > 0) begin
			dmem_wait--;
			busywait = 1'b1;
		end else begin
			busywait = 1'b0;
		end
	endtask

	task automatic serve_memories();
		forever begin
			@(negedge CLK);
			sample_ports();
			@(posedge CLK);
			#1;
			drive_memories();
		end
	endtask

	// ##########################################################################
	// main sequence
	// ##########################################################################
	initial begin
		int seed;
		RESET          = 1'b0;
		instruction    = '0;
		instr_busywait = 1'b1;
		busywait       = 1'b0;
		seed = $urandom(58);                   // one seed for the run
		for (int a = 0; a < 256; a++)
			dmem[a] = 8'($urandom);
		build_program();
		run_model();
		fetch_total = exp_fetch.size();
		fork
			serve_memories();
		join_none
		repeat (5) @(posedge CLK);
		#1;
		RESET = 1'b1;
		while (fetch_count < fetch_total)
			@(posedge CLK);
		repeat (4) @(posedge CLK);             // a few turns of the self-loop
		if (exp_store.size() != 0)
			report_error($sformatf("%0d expected stores never seen", exp_store.size()));
		$display("%0d errors, %0d fetches and %0d stores checked",
			errors, fetch_count, store_count);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge CLK);
		$display("ERROR: watchdog expired after %0d cycles, program never finished",
			watchdog_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== rtl/cpu.sv ====
// top level of the 8-bit single-cycle core
// splits the instruction, forms the stall and drives both memory ports

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
	input  logic                    CLK,
	input  logic                    RESET,
	output cpu_pkg::imem_req_t      imem_req,
	input  logic [`CPU_INSTR_W-1:0] instruction,
	input  logic                    instr_busywait,
	output cpu_pkg::dmem_req_t      dmem_req,
	input  logic [`CPU_DATA_W-1:0]  readdata,
	input  logic                    busywait
);

	logic [`CPU_OPCODE_MSB-`CPU_OPCODE_LSB:0] opcode;
	logic [`CPU_REG_ADDR_W-1:0] dest;
	logic [`CPU_REG_ADDR_W-1:0] src1;
	logic [`CPU_REG_ADDR_W-1:0] src2;
	logic [`CPU_DATA_W-1:0]     imm;
	logic [`CPU_DATA_W-1:0]     offset;
	logic                       stall;
	logic                       instr_valid;   // fetched word is good this cycle
	cpu_pkg::ctrl_t             ctrl_dec;
	cpu_pkg::ctrl_t             ctrl;
	logic [`CPU_DATA_W-1:0]     read_data1;
	logic [`CPU_DATA_W-1:0]     read_data2;
	logic [`CPU_DATA_W-1:0]     alu_result;
	logic                       zero;
	logic [`CPU_DATA_W-1:0]     write_data;

	// ##########################################################################
	// instruction fields and stall
	// ##########################################################################
	assign opcode = instruction[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB];
	assign dest   = instruction[`CPU_DEST_LSB +: `CPU_REG_ADDR_W];
	assign src1   = instruction[`CPU_SRC1_LSB +: `CPU_REG_ADDR_W];
	assign src2   = instruction[`CPU_SRC2_LSB +: `CPU_REG_ADDR_W];
	assign imm    = instruction[`CPU_IMM_LSB +: `CPU_DATA_W];
	assign offset = instruction[`CPU_DEST_LSB +: `CPU_DATA_W];   // j and beq

	assign stall       = busywait | (imem_req.read & instr_busywait);
	assign instr_valid = imem_req.read & ~instr_busywait;
	assign ctrl        = instr_valid ? ctrl_dec : '0;   // no side effects on a stale word

	// ##########################################################################
	// core blocks
	// ##########################################################################
	pc_unit u_pc_unit (.CLK(CLK), .RESET(RESET), .stall(stall), .ctrl(ctrl),
		.zero(zero), .offset(offset), .imem_req(imem_req));

	control_unit u_control_unit (.opcode(opcode), .ctrl(ctrl_dec));

	reg_file u_reg_file (.CLK(CLK), .RESET(RESET), .write_en(ctrl.reg_write),
		.stall(stall), .write_addr(dest), .read_addr1(src1), .read_addr2(src2),
		.write_data(write_data), .read_data1(read_data1), .read_data2(read_data2));

	alu u_alu (.ctrl(ctrl), .reg_operand1(read_data1), .reg_operand2(read_data2),
		.immediate(imm), .result(alu_result), .zero(zero));

	// ##########################################################################
	// data memory and write-back
	// ##########################################################################
	always_comb begin
		dmem_req.read      = ctrl.mem_read;    // held until busywait drops
		dmem_req.write     = ctrl.mem_write;
		dmem_req.address   = alu_result;       // fwd of rs2 or imm
		dmem_req.writedata = read_data1;       // store data from rs1
	end

	assign write_data = ctrl.mem_to_reg ? readdata : alu_result;

endmodule

// ==== rtl/alu.sv ====
// arithmetic and logic unit
// picks operand 2, applies the operation and flags a zero result

`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
	input  cpu_pkg::ctrl_t         ctrl,
	input  logic [`CPU_DATA_W-1:0] reg_operand1,
	input  logic [`CPU_DATA_W-1:0] reg_operand2,
	input  logic [`CPU_DATA_W-1:0] immediate,
	output logic [`CPU_DATA_W-1:0] result,
	output logic                   zero
);

	logic [`CPU_DATA_W-1:0] operand2_sel;   // imm or rs2
	logic [`CPU_DATA_W-1:0] operand2;       // after optional negation

	// ##########################################################################
	// operand 2
	// ##########################################################################
	assign operand2_sel = ctrl.use_reg_operand ? reg_operand2 : immediate;
	assign operand2     = ctrl.negate ? -operand2_sel : operand2_sel;   // sub and beq

	// ##########################################################################
	// operation
	// ##########################################################################
	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::alu_fwd: result = operand2;
			cpu_pkg::alu_add: result = reg_operand1 + operand2;   // wraps mod 256
			cpu_pkg::alu_and: result = reg_operand1 & operand2;
			cpu_pkg::alu_or:  result = reg_operand1 | operand2;
			default:          result = '0;
		endcase
	end

	assign zero = (result == '0);   // beq compares through rs1 - rs2

endmodule

// ==== rtl/reg_file.sv ====
// eight-entry register file
// two combinational read ports, one write port held off by the stall

`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_file (
	input  logic                       CLK,
	input  logic                       RESET,
	input  logic                       write_en,
	input  logic                       stall,
	input  logic [`CPU_REG_ADDR_W-1:0] write_addr,
	input  logic [`CPU_REG_ADDR_W-1:0] read_addr1,
	input  logic [`CPU_REG_ADDR_W-1:0] read_addr2,
	input  logic [`CPU_DATA_W-1:0]     write_data,
	output logic [`CPU_DATA_W-1:0]     read_data1,
	output logic [`CPU_DATA_W-1:0]     read_data2
);

	logic [`CPU_REG_COUNT-1:0][`CPU_DATA_W-1:0] regs;

	// ##########################################################################
	// write port
	// ##########################################################################
	always_ff @(posedge CLK) begin
		if (!RESET)
			regs <= '0;                        // all registers cleared
		else if (write_en && !stall)
			regs[write_addr] <= write_data;    // commits once, at the last edge
	end

	// read ports, no bypass needed in a single-cycle core
	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

	regs_hold: assert property (@(posedge CLK) disable iff (!RESET)
		stall |=> $stable(regs))
		else $error("register written during a stall");

endmodule

// ==== rtl/control_unit.sv ====
// instruction decoder
// maps the opcode byte onto the control struct

`timescale 1ns/1ps
`include "cpu_settings.svh"

module control_unit (
	input  logic [`CPU_OPCODE_MSB-`CPU_OPCODE_LSB:0] opcode,
	output cpu_pkg::ctrl_t                          ctrl
);

	always_comb begin
		ctrl        = '0;                // nothing happens unless decoded
		ctrl.alu_op = cpu_pkg::alu_fwd;
		case (cpu_pkg::opcode_e'(opcode))
			cpu_pkg::op_loadi: begin
				ctrl.reg_write = 1'b1;   // imm straight through
			end
			cpu_pkg::op_mov: begin
				ctrl.reg_write       = 1'b1;
				ctrl.use_reg_operand = 1'b1;
			end
			cpu_pkg::op_add: begin
				ctrl.reg_write       = 1'b1;
				ctrl.alu_op          = cpu_pkg::alu_add;
				ctrl.use_reg_operand = 1'b1;
			end
			cpu_pkg::op_sub: begin
				ctrl.reg_write       = 1'b1;
				ctrl.alu_op          = cpu_pkg::alu_add;   // rs1 + (-rs2)
				ctrl.use_reg_operand = 1'b1;
				ctrl.negate          = 1'b1;
			end
			cpu_pkg::op_and: begin
				ctrl.reg_write       = 1'b1;
				ctrl.alu_op          = cpu_pkg::alu_and;
				ctrl.use_reg_operand = 1'b1;
			end
			cpu_pkg::op_or: begin
				ctrl.reg_write       = 1'b1;
				ctrl.alu_op          = cpu_pkg::alu_or;
				ctrl.use_reg_operand = 1'b1;
			end
			cpu_pkg::op_j: begin
				ctrl.jump = 1'b1;        // alu result unused
			end
			cpu_pkg::op_beq: begin
				ctrl.alu_op          = cpu_pkg::alu_add;   // zero flag on rs1 - rs2
				ctrl.use_reg_operand = 1'b1;
				ctrl.negate          = 1'b1;
				ctrl.branch          = 1'b1;
			end
			cpu_pkg::op_lwd: begin
				ctrl.reg_write       = 1'b1;
				ctrl.use_reg_operand = 1'b1;   // address from rs2
				ctrl.mem_read        = 1'b1;
				ctrl.mem_to_reg      = 1'b1;
			end
			cpu_pkg::op_lwi: begin
				ctrl.reg_write  = 1'b1;        // address from imm
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			cpu_pkg::op_swd: begin
				ctrl.use_reg_operand = 1'b1;
				ctrl.mem_write       = 1'b1;   // data from rs1
			end
			cpu_pkg::op_swi: begin
				ctrl.mem_write = 1'b1;
			end
			default: ctrl = '0;                // unknown opcode, no side effects
		endcase
	end

	rw_exclusive: assert property (@(opcode) !(ctrl.mem_read && ctrl.mem_write))
		else $error("read and write decoded together, opcode %h", opcode);

endmodule

// ==== rtl/pc_unit.sv ====
// program counter with branch and jump targets
// holds on stall, drives the instruction fetch request

`timescale 1ns/1ps
`include "cpu_settings.svh"

module pc_unit (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   stall,
	input  cpu_pkg::ctrl_t         ctrl,
	input  logic                   zero,
	input  logic [`CPU_DATA_W-1:0] offset,
	output cpu_pkg::imem_req_t     imem_req
);

	logic [`CPU_INSTR_W-1:0] pc;
	logic                    fetch_en;   // low until the first fetch after reset
	logic [`CPU_INSTR_W-1:0] pc_plus4;
	logic [`CPU_INSTR_W-1:0] target;
	logic [`CPU_INSTR_W-1:0] pc_next;
	logic                    take;

	// ##########################################################################
	// next pc
	// ##########################################################################
	assign pc_plus4 = pc + 32'd4;
	// offset counts words, sign extend then times four
	assign target = pc_plus4 +
		{{(`CPU_INSTR_W-`CPU_DATA_W-2){offset[`CPU_DATA_W-1]}}, offset, 2'b00};
	assign take    = (ctrl.branch & zero) | ctrl.jump;   // beq taken or j
	assign pc_next = take ? target : pc_plus4;

	// ##########################################################################
	// pc register
	// ##########################################################################
	always_ff @(posedge CLK) begin
		if (!RESET) begin
			pc       <= '0;     // start at word 0
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;   // fetch from the first cycle out of reset
			if (fetch_en && !stall)
				pc <= pc_next;  // instruction done, move on
		end
	end

	assign imem_req.read = fetch_en;
	assign imem_req.addr = pc;

	pc_aligned: assert property (@(posedge CLK) disable iff (!RESET)
		pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

// ==== rtl/cpu_pkg.sv ====
// shared types of the processor core
// opcode and alu encodings, decoded control and both memory requests

`include "cpu_settings.svh"

package cpu_pkg;

	typedef enum logic [`CPU_OPCODE_MSB-`CPU_OPCODE_LSB:0] {
		op_loadi = 8'd0,   // rd <- imm
		op_mov   = 8'd1,   // rd <- rs2
		op_add   = 8'd2,
		op_sub   = 8'd3,
		op_and   = 8'd4,
		op_or    = 8'd5,
		op_j     = 8'd6,   // unconditional, offset in 23:16
		op_beq   = 8'd7,   // taken when rs1 == rs2
		op_lwd   = 8'd8,   // address from rs2
		op_lwi   = 8'd9,   // address from imm
		op_swd   = 8'd10,
		op_swi   = 8'd11
	} opcode_e;

	typedef enum logic [2:0] {
		alu_fwd = 3'd0,   // pass operand 2
		alu_add = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3
	} alu_op_e;

	typedef struct packed {
		logic    reg_write;        // commit rd at the end of the instruction
		alu_op_e alu_op;
		logic    use_reg_operand;  // rs2 instead of imm
		logic    negate;           // two's complement of operand 2
		logic    branch;           // beq
		logic    jump;             // j
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;       // write back readdata
	} ctrl_t;

	typedef struct packed {
		logic                    read;
		logic [`CPU_INSTR_W-1:0] addr;   // byte address, word aligned
	} imem_req_t;

	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [`CPU_DATA_W-1:0] address;
		logic [`CPU_DATA_W-1:0] writedata;
	} dmem_req_t;

endpackage

// ==== rtl/cpu_settings.svh ====
// core settings for the 8-bit single-cycle processor
// widths, register count and instruction field positions

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ##########################################################################
// widths
// ##########################################################################
`define CPU_DATA_W      8   // data path and register width
`define CPU_INSTR_W     32  // instruction word and pc width
`define CPU_REG_COUNT   8   // entries in the register file
`define CPU_REG_ADDR_W  3   // register index bits

// ##########################################################################
// instruction fields
// ##########################################################################
`define CPU_OPCODE_MSB  31  // opcode is the top byte
`define CPU_OPCODE_LSB  24
`define CPU_DEST_LSB    16  // rd in 18:16, branch offset in 23:16
`define CPU_SRC1_LSB    8   // rs1 in 10:8
`define CPU_SRC2_LSB    0   // rs2 in 2:0
`define CPU_IMM_LSB     0   // immediate in 7:0

`endif
